// File: list.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/register_bank.sv
logic/control_unit.sv
logic/execution.sv
logic/mips_core.sv
test/tb_mips_core.sv

// File: Makefile
# Verilator build and run of the MIPS core testbench
# Any variable below can be overridden, e.g. make test TOP=tb_mips_core

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Exit status of the simulation is the result of the run
test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_mips_core.sv
`default_nettype none

`include "mips_config.svh"

module tb_mips_core;

    timeunit 1ns;
    timeprecision 1ps;

    // One table row, expected write-back packed with its flags
    typedef struct packed {
        mips_isa_pkg::data_t instr;
        logic                b2b;       // Zero gap before this row
        logic                wr;        // Row expects a write-back
        mips_pipe_pkg::wb_t  exp;
    } row_t;

    logic                 i_clock;
    logic                 i_arst_n;
    logic                 i_instr_valid;
    mips_isa_pkg::data_t  i_instr;
    logic                 o_wb_valid;
    mips_pipe_pkg::wb_t   o_wb;

    row_t               rows[$];
    mips_pipe_pkg::wb_t expected[$];     // Write-backs still to come, in order
    mips_pipe_pkg::wb_t exp_wb;
    logic [19:0]        lfsr_state = 20'd85680;
    int                 cycles = 0;
    int                 cycle_limit;

    mips_core DUT (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb          (o_wb)
    );

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;   // 8 ns period
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_reg_addr(input string name, input mips_isa_pkg::reg_addr_t got,
                                  input mips_isa_pkg::reg_addr_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input mips_isa_pkg::data_t got,
                              input mips_isa_pkg::data_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Fibonacci LFSR, taps 20 and 17
    function automatic logic [19:0] lfsr_next(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    task automatic next_gap(output logic [1:0] gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap[0]     = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap[1]     = lfsr_state[0];      // One step per bit
    endtask

    function automatic mips_isa_pkg::data_t enc_r(input mips_isa_pkg::funct_e fn, input int rd,
                                                 input int rs, input int rt, input int shamt);
        mips_isa_pkg::instr_r_t instr;
        instr.op    = mips_isa_pkg::OP_RTYPE;
        instr.rs    = rs[`NB_REG_ADDRESS-1:0];
        instr.rt    = rt[`NB_REG_ADDRESS-1:0];
        instr.rd    = rd[`NB_REG_ADDRESS-1:0];
        instr.shamt = shamt[`NB_SHAMT-1:0];
        instr.funct = fn;
        return instr;
    endfunction

    function automatic mips_isa_pkg::data_t enc_i(input mips_isa_pkg::opcode_e op, input int rt,
                                                 input int rs, input int imm);
        mips_isa_pkg::instr_i_t instr;
        instr.op  = op;
        instr.rs  = rs[`NB_REG_ADDRESS-1:0];
        instr.rt  = rt[`NB_REG_ADDRESS-1:0];   // I-type destination
        instr.imm = imm[`NB_IMMEDIATE-1:0];
        return instr;
    endfunction

    task automatic add_row(input int b2b, input mips_isa_pkg::data_t instr, input int wr,
                           input int addr, input mips_isa_pkg::data_t data);
        row_t r;
        r.instr    = instr;
        r.b2b      = (b2b != 0);
        r.wr       = (wr != 0);
        r.exp.addr = addr[`NB_REG_ADDRESS-1:0];
        r.exp.data = data;
        rows.push_back(r);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus table, results worked out from the ISA rules
    // ----------------------------------------------------------------------
    task automatic build_table();
        add_row(0, enc_i(mips_isa_pkg::OP_LUI, 1, 0, 'h1234), 1, 1, 32'h12340000);
        add_row(1, enc_i(mips_isa_pkg::OP_ORI, 1, 1, 'h5678), 1, 1, 32'h12345678);
        add_row(0, enc_i(mips_isa_pkg::OP_ADDIU, 2, 0, 'hFFFF), 1, 2, 32'hFFFFFFFF);
        add_row(0, enc_i(mips_isa_pkg::OP_ANDI, 3, 2, 'h8001), 1, 3, 32'h00008001);
        add_row(0, enc_i(mips_isa_pkg::OP_XORI, 4, 2, 'h00FF), 1, 4, 32'hFFFFFF00);
        add_row(0, enc_i(mips_isa_pkg::OP_ADDIU, 5, 1, 'h8000), 1, 5, 32'h1233D678);
        add_row(0, enc_r(mips_isa_pkg::FN_ADDU, 6, 2, 1, 0), 1, 6, 32'h12345677);  // Wraps
        add_row(0, enc_r(mips_isa_pkg::FN_SUBU, 7, 0, 1, 0), 1, 7, 32'hEDCBA988);
        add_row(0, enc_r(mips_isa_pkg::FN_AND, 8, 1, 4, 0), 1, 8, 32'h12345600);
        add_row(0, enc_r(mips_isa_pkg::FN_OR, 9, 3, 1, 0), 1, 9, 32'h1234D679);
        add_row(0, enc_r(mips_isa_pkg::FN_XOR, 10, 1, 2, 0), 1, 10, 32'hEDCBA987);
        add_row(0, enc_r(mips_isa_pkg::FN_NOR, 11, 1, 3, 0), 1, 11, 32'hEDCB2986);
        // Signed and unsigned compares of -1 against positives
        add_row(0, enc_r(mips_isa_pkg::FN_SLT, 12, 2, 1, 0), 1, 12, 32'h00000001);
        add_row(0, enc_r(mips_isa_pkg::FN_SLTU, 13, 2, 1, 0), 1, 13, 32'h00000000);
        add_row(0, enc_i(mips_isa_pkg::OP_SLTI, 14, 2, 'h0001), 1, 14, 32'h00000001);
        add_row(0, enc_i(mips_isa_pkg::OP_SLTIU, 15, 2, 'h0001), 1, 15, 32'h00000000);
        add_row(0, enc_i(mips_isa_pkg::OP_SLTIU, 16, 3, 'hFFFF), 1, 16, 32'h00000001);
        add_row(0, enc_r(mips_isa_pkg::FN_SLL, 17, 0, 1, 4), 1, 17, 32'h23456780);
        add_row(0, enc_r(mips_isa_pkg::FN_SRL, 18, 0, 4, 8), 1, 18, 32'h00FFFFFF);
        add_row(0, enc_r(mips_isa_pkg::FN_SRA, 19, 0, 4, 8), 1, 19, 32'hFFFFFFFF);
        add_row(0, enc_r(mips_isa_pkg::FN_SRA, 20, 0, 1, 4), 1, 20, 32'h01234567);
        // Dependent chain with zero gaps
        add_row(0, enc_i(mips_isa_pkg::OP_ADDIU, 21, 0, 'h0005), 1, 21, 32'h00000005);
        add_row(1, enc_r(mips_isa_pkg::FN_ADDU, 21, 21, 21, 0), 1, 21, 32'h0000000A);
        add_row(1, enc_r(mips_isa_pkg::FN_ADDU, 22, 21, 21, 0), 1, 22, 32'h00000014);
        add_row(1, enc_r(mips_isa_pkg::FN_SUBU, 23, 22, 21, 0), 1, 23, 32'h0000000A);
        add_row(0, enc_i(mips_isa_pkg::OP_ADDIU, 0, 0, 'h7777), 1, 0, 32'h00007777);  // r0
        add_row(1, enc_r(mips_isa_pkg::FN_ADDU, 24, 0, 1, 0), 1, 24, 32'h12345678);
        add_row(0, {6'h23, 5'd1, 5'd24, 16'h1111}, 0, 0, 32'h0);          // Load opcode
        add_row(0, {6'h00, 5'd1, 5'd2, 5'd24, 5'd0, 6'h3F}, 0, 0, 32'h0); // Bad function
        add_row(1, enc_i(mips_isa_pkg::OP_ORI, 25, 24, 'h0000), 1, 25, 32'h12345678);
        add_row(0, enc_r(mips_isa_pkg::FN_ADDU, 26, 23, 22, 0), 1, 26, 32'h0000001E);
    endtask

    // ----------------------------------------------------------------------
    // Monitor and timeout
    // ----------------------------------------------------------------------
    always @(negedge i_clock) begin
        if (i_arst_n && o_wb_valid) begin
            if (expected.size() == 0) begin
                fail_run("A write-back was reported while no result was expected");
            end else begin
                exp_wb = expected.pop_front();
                check_reg_addr("o_wb.addr", o_wb.addr, exp_wb.addr);
                check_data("o_wb.data", o_wb.data, exp_wb.data);
            end
        end
    end

    always @(posedge i_clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            fail_run("The run did not finish within the cycle limit");
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        row_t        r;
        logic [1:0]  gap;
        i_arst_n      = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        build_table();
        cycle_limit = rows.size() * (3 + 2) + 20;

        repeat (5) @(posedge i_clock);
        i_arst_n <= 1'b1;                // Reset held 5 cycles

        foreach (rows[k]) begin
            r = rows[k];
            if (!r.b2b) begin
                next_gap(gap);
                repeat (gap) begin
                    @(posedge i_clock);
                    i_instr_valid <= 1'b0;
                end
            end
            @(posedge i_clock);
            i_instr_valid <= 1'b1;
            i_instr       <= r.instr;
            if (r.wr)
                expected.push_back(r.exp);
        end
        @(posedge i_clock);
        i_instr_valid <= 1'b0;

        repeat (3) @(posedge i_clock);   // Latency is fixed at two cycles
        if (expected.size() != 0) begin
            fail_run($sformatf("%0d expected write-backs never arrived", expected.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: logic/mips_core.sv
`default_nettype none

module mips_core (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_instr_valid,  // One strobe per instruction
    input  mips_isa_pkg::data_t  i_instr,
    output logic                 o_wb_valid,     // Result strobe, two cycles later
    output mips_pipe_pkg::wb_t   o_wb
);

    mips_pipe_pkg::operands_t operands;          // rs and rt read data
    mips_pipe_pkg::ctrl_t     ctrl;              // Decoded control
    logic                     ex_fwd_valid;
    mips_pipe_pkg::wb_t       ex_fwd;            // Execute result back to register read

    // ----------------------------------------------------------------------
    // Register read and decode, side by side on the incoming word
    // ----------------------------------------------------------------------
    register_bank u_register_bank (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_instr        (i_instr),
        .i_ex_fwd_valid (ex_fwd_valid),
        .i_ex_fwd       (ex_fwd),
        .i_wb_valid     (o_wb_valid),            // Write port fed by write-back
        .i_wb           (o_wb),
        .o_operands     (operands)
    );

    control_unit u_control_unit (
        .i_instr (i_instr),
        .o_ctrl  (ctrl)
    );

    // ----------------------------------------------------------------------
    // Execute and write-back
    // ----------------------------------------------------------------------
    execution u_execution (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_operands     (operands),
        .i_ctrl         (ctrl),
        .o_ex_fwd_valid (ex_fwd_valid),
        .o_ex_fwd       (ex_fwd),
        .o_wb_valid     (o_wb_valid),
        .o_wb           (o_wb)
    );

endmodule

`default_nettype wire

// File: logic/execution.sv
`default_nettype none

`include "mips_config.svh"

module execution (
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic                      i_instr_valid,     // One cycle strobe
    input  mips_isa_pkg::instr_i_t    i_instr,
    input  mips_pipe_pkg::operands_t  i_operands,
    input  mips_pipe_pkg::ctrl_t      i_ctrl,
    output logic                      o_ex_fwd_valid,    // Execute result is a register write
    output mips_pipe_pkg::wb_t        o_ex_fwd,
    output logic                      o_wb_valid,
    output mips_pipe_pkg::wb_t        o_wb
);

    logic                      id_ex_valid;
    mips_isa_pkg::instr_i_t    id_ex_instr;
    mips_isa_pkg::instr_r_t    id_ex_instr_r;   // Same bits seen in R layout
    mips_pipe_pkg::operands_t  id_ex_ops;
    mips_pipe_pkg::ctrl_t      id_ex_ctrl;
    mips_isa_pkg::data_t       imm_ext;
    mips_isa_pkg::data_t       op_a;
    mips_isa_pkg::data_t       op_b;
    mips_isa_pkg::data_t       alu_res;
    mips_isa_pkg::data_t       result;

    // ----------------------------------------------------------------------
    // ID/EX register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) id_ex_valid <= 1'b0;
        else           id_ex_valid <= i_instr_valid && i_ctrl.reg_write;  // Drops non-writers
    end

    always_ff @(posedge i_clock) begin
        if (i_instr_valid) begin
            id_ex_instr <= i_instr;
            id_ex_ops   <= i_operands;
            id_ex_ctrl  <= i_ctrl;
        end
    end

    assign id_ex_instr_r = id_ex_instr;         // For rd and shamt

    // ----------------------------------------------------------------------
    // Operand select and ALU
    // ----------------------------------------------------------------------
    always_comb begin
        case (id_ex_ctrl.imm_ext)
            mips_pipe_pkg::EXT_ZERO:  imm_ext = {{(`NB_DATA-`NB_IMMEDIATE){1'b0}}, id_ex_instr.imm};
            mips_pipe_pkg::EXT_UPPER: imm_ext = {id_ex_instr.imm, {(`NB_DATA-`NB_IMMEDIATE){1'b0}}};
            default: imm_ext = {{(`NB_DATA-`NB_IMMEDIATE){id_ex_instr.imm[`NB_IMMEDIATE-1]}},
                                id_ex_instr.imm};                      // Sign extension
        endcase
    end

    // LUI ignores rs
    assign op_a = (id_ex_ctrl.imm_ext == mips_pipe_pkg::EXT_UPPER) ? '0 : id_ex_ops.ra;
    assign op_b = id_ex_ctrl.alu_src_imm ? imm_ext : id_ex_ops.rb;

    always_comb begin
        alu_res = '0;
        case (id_ex_ctrl.alu_op)
            mips_pipe_pkg::ALU_ADD:  alu_res = op_a + op_b;           // Wraps mod 2^32
            mips_pipe_pkg::ALU_SUB:  alu_res = op_a - op_b;
            mips_pipe_pkg::ALU_AND:  alu_res = op_a & op_b;
            mips_pipe_pkg::ALU_OR:   alu_res = op_a | op_b;
            mips_pipe_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            mips_pipe_pkg::ALU_NOR:  alu_res = ~(op_a | op_b);
            mips_pipe_pkg::ALU_SLT:  alu_res[0] = $signed(op_a) < $signed(op_b);
            mips_pipe_pkg::ALU_SLTU: alu_res[0] = op_a < op_b;
            default:                 alu_res = '0;
        endcase
    end

    // Shifts act on rt by shamt
    always_comb begin
        case (id_ex_ctrl.shift)
            mips_pipe_pkg::SH_SLL: result = id_ex_ops.rb << id_ex_instr_r.shamt;
            mips_pipe_pkg::SH_SRL: result = id_ex_ops.rb >> id_ex_instr_r.shamt;
            mips_pipe_pkg::SH_SRA: result = $signed(id_ex_ops.rb) >>> id_ex_instr_r.shamt;
            default:               result = alu_res;
        endcase
    end

    // ----------------------------------------------------------------------
    // Forward path and write-back register
    // ----------------------------------------------------------------------
    assign o_ex_fwd_valid = id_ex_valid;
    assign o_ex_fwd.addr  = id_ex_ctrl.reg_dst_rd ? id_ex_instr_r.rd : id_ex_instr.rt;
    assign o_ex_fwd.data  = result;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) o_wb_valid <= 1'b0;
        else           o_wb_valid <= id_ex_valid;
    end

    always_ff @(posedge i_clock) begin
        o_wb <= o_ex_fwd;           // Payload follows the valid bit
    end

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`default_nettype none

module control_unit (
    input  mips_isa_pkg::instr_r_t i_instr,
    output mips_pipe_pkg::ctrl_t   o_ctrl
);

    // ----------------------------------------------------------------------
    // Opcode and function decode
    // ----------------------------------------------------------------------
    always_comb begin
        o_ctrl             = '0;                        // Nothing written by default
        o_ctrl.alu_op      = mips_pipe_pkg::ALU_ADD;
        o_ctrl.shift       = mips_pipe_pkg::SH_NONE;
        o_ctrl.imm_ext     = mips_pipe_pkg::EXT_SIGN;

        case (i_instr.op)
            mips_isa_pkg::OP_RTYPE: begin
                o_ctrl.reg_dst_rd = 1'b1;               // R-type writes rd
                o_ctrl.reg_write  = 1'b1;
                case (i_instr.funct)
                    mips_isa_pkg::FN_SLL:  o_ctrl.shift  = mips_pipe_pkg::SH_SLL;
                    mips_isa_pkg::FN_SRL:  o_ctrl.shift  = mips_pipe_pkg::SH_SRL;
                    mips_isa_pkg::FN_SRA:  o_ctrl.shift  = mips_pipe_pkg::SH_SRA;
                    mips_isa_pkg::FN_ADDU: o_ctrl.alu_op = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: o_ctrl.alu_op = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  o_ctrl.alu_op = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   o_ctrl.alu_op = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  o_ctrl.alu_op = mips_pipe_pkg::ALU_XOR;
                    mips_isa_pkg::FN_NOR:  o_ctrl.alu_op = mips_pipe_pkg::ALU_NOR;
                    mips_isa_pkg::FN_SLT:  o_ctrl.alu_op = mips_pipe_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: o_ctrl.alu_op = mips_pipe_pkg::ALU_SLTU;
                    default:               o_ctrl.reg_write = 1'b0;  // Unknown function
                endcase
            end

            // I-type keeps reg_dst_rd low so rt is the destination
            mips_isa_pkg::OP_ADDIU: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_SLTI: begin
                o_ctrl.alu_op      = mips_pipe_pkg::ALU_SLT;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_SLTIU: begin
                o_ctrl.alu_op      = mips_pipe_pkg::ALU_SLTU;   // Sign extended, compared unsigned
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_ANDI: begin
                o_ctrl.alu_op      = mips_pipe_pkg::ALU_AND;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm_ext     = mips_pipe_pkg::EXT_ZERO;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_ORI: begin
                o_ctrl.alu_op      = mips_pipe_pkg::ALU_OR;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm_ext     = mips_pipe_pkg::EXT_ZERO;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_XORI: begin
                o_ctrl.alu_op      = mips_pipe_pkg::ALU_XOR;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm_ext     = mips_pipe_pkg::EXT_ZERO;
                o_ctrl.reg_write   = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                o_ctrl.alu_src_imm = 1'b1;                      // Zero plus upper immediate
                o_ctrl.imm_ext     = mips_pipe_pkg::EXT_UPPER;
                o_ctrl.reg_write   = 1'b1;
            end
            default: begin
                o_ctrl.reg_write = 1'b0;                        // Unsupported opcode
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/register_bank.sv
`default_nettype none

`include "mips_config.svh"

module register_bank (
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  mips_isa_pkg::instr_r_t i_instr,         // Instruction being decoded
    input  logic                   i_ex_fwd_valid,  // Execute stage writes a register
    input  mips_pipe_pkg::wb_t     i_ex_fwd,        // Execute stage result
    input  logic                   i_wb_valid,
    input  mips_pipe_pkg::wb_t     i_wb,
    output mips_pipe_pkg::operands_t o_operands
);

    mips_isa_pkg::data_t regs [`N_REGS];

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_valid && (i_wb.addr != '0)) begin  // r0 stays zero
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports with bypass
    // ----------------------------------------------------------------------
    // Youngest value wins
    // Execute result first, then the write in progress, then the array
    function automatic mips_isa_pkg::data_t read_reg(input mips_isa_pkg::reg_addr_t addr);
        mips_isa_pkg::data_t value;
        if (addr == '0) begin
            value = '0;                                     // Hardwired zero
        end else if (i_ex_fwd_valid && (i_ex_fwd.addr == addr)) begin
            value = i_ex_fwd.data;                          // Forward from execute
        end else if (i_wb_valid && (i_wb.addr == addr)) begin
            value = i_wb.data;                              // Write-through
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        o_operands.ra = read_reg(i_instr.rs);
        o_operands.rb = read_reg(i_instr.rt);
    end

endmodule

`default_nettype wire

// File: logic/mips_pipe_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pipe_pkg;

    // ----------------------------------------------------------------------
    // Execute stage operation selects
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,    // Signed compare
        ALU_SLTU    // Unsigned compare
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE,    // Result comes from the ALU
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_e;

    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO,
        EXT_UPPER   // Immediate placed in the high half
    } imm_ext_e;

    // Decoded control, carried through ID/EX
    typedef struct packed {
        alu_op_e  alu_op;
        shift_e   shift;
        logic     alu_src_imm;  // Operand B from the immediate
        imm_ext_e imm_ext;
        logic     reg_dst_rd;   // Write rd instead of rt
        logic     reg_write;
    } ctrl_t;

    // Register read data for rs and rt
    typedef struct packed {
        mips_isa_pkg::data_t ra;
        mips_isa_pkg::data_t rb;
    } operands_t;

    // One register write
    typedef struct packed {
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::data_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/mips_isa_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_isa_pkg;

    typedef logic [`NB_DATA-1:0]        data_t;      // One data word
    typedef logic [`NB_REG_ADDRESS-1:0] reg_addr_t;  // Register index

    // ----------------------------------------------------------------------
    // Opcode and function encodings
    // ----------------------------------------------------------------------
    typedef enum logic [`NB_OP_FIELD-1:0] {
        OP_RTYPE = 6'h00,   // Function field selects the operation
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F
    } opcode_e;

    typedef enum logic [`NB_OP_FIELD-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // ----------------------------------------------------------------------
    // Instruction layouts, both 32 bits wide
    // ----------------------------------------------------------------------
    typedef struct packed {
        opcode_e                     op;
        reg_addr_t                   rs;
        reg_addr_t                   rt;
        reg_addr_t                   rd;     // Destination of R-type
        logic [`NB_SHAMT-1:0]        shamt;
        funct_e                      funct;
    } instr_r_t;

    typedef struct packed {
        opcode_e                     op;
        reg_addr_t                   rs;
        reg_addr_t                   rt;     // Destination of I-type
        logic [`NB_IMMEDIATE-1:0]    imm;
    } instr_i_t;

endpackage

`default_nettype wire

// File: logic/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ----------------------------------------------------------------------
// Datapath sizes
// ----------------------------------------------------------------------
`define NB_DATA         32  // Data word width
`define NB_REG_ADDRESS  5   // Register index width
`define N_REGS          32  // Registers in the bank

// Instruction field widths
`define NB_OP_FIELD     6   // Opcode and function fields
`define NB_SHAMT        5   // Shift amount
`define NB_IMMEDIATE    16  // I-type immediate

`endif
